// ==== Makefile ====
SIM      = verilator
FLAGS    = --binary --timing --assert -j 0
LINT     = --lint-only --timing -Wall
TOP      = tb_mix_top
FILELIST = sim.f
OBJ_DIR  = obj_dir
LOG      = sim.log
RUN_ARGS = +verilator+error+limit+100

.PHONY: all build run lint clean

all: run

build:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR) -o V$(TOP)

run: build
	./$(OBJ_DIR)/V$(TOP) $(RUN_ARGS) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "Verification failed" $(LOG); then echo "simulation FAILED"; exit 1; fi
	@if ! grep -q "Verification passed" $(LOG); then echo "simulation did not finish"; exit 1; fi

lint:
	$(SIM) $(LINT) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== design/lane_collect.sv ====
`timescale 1ns/100ps

module lane_collect (
    input  logic           clk,
    input  logic           rst_n,

    // one stream per lane
    stream_if.sink         i_lanes [mix_pkg::NUM_LANES],

    // output stream
    output logic           o_valid,
    input  logic           i_ready,
    output mix_pkg::word_t o_data,
    output logic           o_last
);

    mix_pkg::lane_idx_t            rd_ptr;
    logic [mix_pkg::NUM_LANES-1:0] lane_valid;
    logic [mix_pkg::NUM_LANES-1:0] lane_last;
    mix_pkg::word_t                lane_data [mix_pkg::NUM_LANES];
    logic                          accept;

    for (genvar g = 0; g < mix_pkg::NUM_LANES; g++) begin : g_lane
        // lane outputs into plain arrays for the pointer mux
        assign lane_valid[g]    = i_lanes[g].valid;
        assign lane_data[g]     = i_lanes[g].data;
        assign lane_last[g]     = i_lanes[g].last;
        // only the lane under the pointer is drained
        assign i_lanes[g].ready = i_ready && (rd_ptr == mix_pkg::lane_idx_t'(g));
    end

    // present the selected lane, other lanes wait their turn
    assign o_valid = lane_valid[rd_ptr];
    assign o_data  = lane_data[rd_ptr];
    assign o_last  = lane_last[rd_ptr];

    assign accept = o_valid && i_ready;

    // same rotation as the dispatcher keeps input order
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rd_ptr <= '0;
        end else if (accept) begin
            if (rd_ptr == mix_pkg::lane_idx_t'(mix_pkg::NUM_LANES - 1)) begin
                rd_ptr <= '0;
            end else begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

endmodule

// ==== design/lane_dispatch.sv ====
`timescale 1ns/100ps

module lane_dispatch (
    input  logic           clk,
    input  logic           rst_n,

    // input stream
    input  logic           i_valid,
    output logic           o_ready,
    input  mix_pkg::word_t i_data,
    input  logic           i_last,

    // one stream per lane
    stream_if.source       o_lanes [mix_pkg::NUM_LANES]
);

    mix_pkg::lane_idx_t            wr_ptr;
    logic [mix_pkg::NUM_LANES-1:0] lane_ready;
    logic                          accept;

    for (genvar g = 0; g < mix_pkg::NUM_LANES; g++) begin : g_lane
        // only the selected lane sees valid
        assign o_lanes[g].valid = i_valid && (wr_ptr == mix_pkg::lane_idx_t'(g));
        // payload is broadcast, unselected lanes ignore it
        assign o_lanes[g].data  = i_data;
        assign o_lanes[g].last  = i_last;
        // interface arrays need constant indices, gather ready into a vector
        assign lane_ready[g]    = o_lanes[g].ready;
    end

    // input ready follows the lane under the pointer
    assign o_ready = lane_ready[wr_ptr];
    assign accept  = i_valid && o_ready;

    // strict round robin, one step per accepted beat
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wr_ptr <= '0;
        end else if (accept) begin
            if (wr_ptr == mix_pkg::lane_idx_t'(mix_pkg::NUM_LANES - 1)) begin
                wr_ptr <= '0;
            end else begin
                wr_ptr <= wr_ptr + 1'b1;
            end
        end
    end

endmodule

// ==== design/mix_lane.sv ====
`timescale 1ns/100ps

module mix_lane (
    input  logic     clk,
    input  logic     rst_n,
    stream_if.sink   i_lane,
    stream_if.source o_lane
);

    mix_pkg::word_t rot_word;
    mix_pkg::beat_t s1_in;
    mix_pkg::beat_t s1_out;
    mix_pkg::beat_t s2_in;
    mix_pkg::beat_t s2_out;
    logic           s1_valid;
    logic           s1_ready;

    // step one, x xor rotl(x, MIX_ROT)
    assign rot_word = (i_lane.data << mix_pkg::MIX_ROT)
                    | (i_lane.data >> (mix_pkg::WORD_W - mix_pkg::MIX_ROT));
    assign s1_in    = {i_lane.last, i_lane.data ^ rot_word};

    pipe_regs #(
        .DATA_WIDTH ($bits(mix_pkg::beat_t))
    ) i_stage1 (
        .clk     (clk),
        .rst_n   (rst_n),
        .i_valid (i_lane.valid),
        .i_ready (i_lane.ready),
        .o_valid (s1_valid),
        .o_ready (s1_ready),
        .i_data  (s1_in),
        .o_data  (s1_out)
    );

    // step two, add the key modulo 2^32
    // last flag in the top bit passes untouched
    assign s2_in = {s1_out[mix_pkg::WORD_W],
                    s1_out[mix_pkg::WORD_W-1:0] + mix_pkg::MIX_KEY};

    pipe_regs #(
        .DATA_WIDTH ($bits(mix_pkg::beat_t))
    ) i_stage2 (
        .clk     (clk),
        .rst_n   (rst_n),
        .i_valid (s1_valid),
        .i_ready (s1_ready),
        .o_valid (o_lane.valid),
        .o_ready (o_lane.ready),
        .i_data  (s2_in),
        .o_data  (s2_out)
    );

    // split the beat back into word and flag
    assign o_lane.data = s2_out[mix_pkg::WORD_W-1:0];
    assign o_lane.last = s2_out[mix_pkg::WORD_W];

endmodule

// ==== design/mix_pkg.sv ====
package mix_pkg;

    // payload width, the lanes store one extra bit for the last flag
    localparam int WORD_W = 32;

    // number of parallel mixing lanes
    localparam int NUM_LANES = 4;

    // rotate amount of the first mixing step
    localparam int MIX_ROT = 13;

    // additive constant of the second mixing step
    localparam logic [WORD_W-1:0] MIX_KEY = 32'h9e37_79b9;

    // one payload word
    typedef logic [WORD_W-1:0] word_t;

    // word plus last flag, flag in the top bit
    typedef logic [WORD_W:0] beat_t;

    // lane pointer for dispatcher and collector
    typedef logic [$clog2(NUM_LANES)-1:0] lane_idx_t;

    // skid register occupancy
    // only the output register holds data in BUSY, both in FULL
    typedef enum logic [1:0] {
        EMPTY = 2'd0,
        BUSY  = 2'd1,
        FULL  = 2'd2
    } pipe_state_e;

endpackage

// ==== design/mix_top.sv ====
`timescale 1ns/100ps

module mix_top (
    input  logic           clk,
    input  logic           rst_n,

    // input stream
    input  logic           i_valid,
    output logic           o_ready,
    input  mix_pkg::word_t i_data,
    input  logic           i_last,

    // output stream
    output logic           o_valid,
    input  logic           i_ready,
    output mix_pkg::word_t o_data,
    output logic           o_last
);

    // dispatcher to lanes
    stream_if lane_in  [mix_pkg::NUM_LANES] ();
    // lanes to collector
    stream_if lane_out [mix_pkg::NUM_LANES] ();

    lane_dispatch i_dispatch (
        .clk     (clk),
        .rst_n   (rst_n),
        .i_valid (i_valid),
        .o_ready (o_ready),
        .i_data  (i_data),
        .i_last  (i_last),
        .o_lanes (lane_in)
    );

    for (genvar g = 0; g < mix_pkg::NUM_LANES; g++) begin : g_lane
        mix_lane i_lane (
            .clk    (clk),
            .rst_n  (rst_n),
            .i_lane (lane_in[g]),
            .o_lane (lane_out[g])
        );
    end

    lane_collect i_collect (
        .clk     (clk),
        .rst_n   (rst_n),
        .i_lanes (lane_out),
        .o_valid (o_valid),
        .i_ready (i_ready),
        .o_data  (o_data),
        .o_last  (o_last)
    );

endmodule

// ==== design/pipe_regs.sv ====
`timescale 1ns/100ps

module pipe_regs #(
    parameter int DATA_WIDTH = 32
) (
    input  logic                  clk,
    input  logic                  rst_n,

    // handshake
    input  logic                  i_valid,
    output logic                  i_ready,
    output logic                  o_valid,
    input  logic                  o_ready,

    // payload
    input  logic [DATA_WIDTH-1:0] i_data,
    output logic [DATA_WIDTH-1:0] o_data
);

    mix_pkg::pipe_state_e  state;
    mix_pkg::pipe_state_e  state_next;

    logic [DATA_WIDTH-1:0] skid_data;
    logic [DATA_WIDTH-1:0] sel_data;
    logic                  out_wren;
    logic                  skid_wren;
    logic                  use_skid;

    logic                  insert;
    logic                  remove;
    logic                  load;
    logic                  flow;
    logic                  fill;
    logic                  flush;
    logic                  unload;

    // beat enters or leaves on this edge
    assign insert = i_valid && i_ready;
    assign remove = o_valid && o_ready;

    // empty datapath takes a beat into the output register
    assign load   = (state == mix_pkg::EMPTY) && insert && !remove;
    // output register replaced while its old beat leaves
    assign flow   = (state == mix_pkg::BUSY) && insert && remove;
    // output stalled, the late beat goes into the skid buffer
    assign fill   = (state == mix_pkg::BUSY) && insert && !remove;
    // skid buffer moves forward as the output drains
    assign flush  = (state == mix_pkg::FULL) && !insert && remove;
    // last beat leaves, nothing behind it
    assign unload = (state == mix_pkg::BUSY) && !insert && remove;

    always_comb begin
        state_next = state;
        if (load || flow || flush) begin
            state_next = mix_pkg::BUSY;
        end
        if (fill) begin
            state_next = mix_pkg::FULL;
        end
        if (unload) begin
            state_next = mix_pkg::EMPTY;
        end
    end

    // register write enables and the output mux select
    assign out_wren  = load || flow || flush;
    assign skid_wren = fill;
    assign use_skid  = flush;

    assign sel_data = use_skid ? skid_data : i_data;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= mix_pkg::EMPTY;
        end else begin
            state <= state_next;
        end
    end

    // ready and valid come straight from the next state
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            i_ready <= 1'b1;
            o_valid <= 1'b0;
        end else begin
            i_ready <= (state_next != mix_pkg::FULL);
            o_valid <= (state_next != mix_pkg::EMPTY);
        end
    end

    // skid buffer
    always_ff @(posedge clk) begin
        if (skid_wren) begin
            skid_data <= i_data;
        end
    end

    // output register
    always_ff @(posedge clk) begin
        if (out_wren) begin
            o_data <= sel_data;
        end
    end

endmodule

// ==== design/stream_if.sv ====
`timescale 1ns/100ps

// valid/ready stream carrying one word and its end-of-packet flag
interface stream_if;

    // driven by the source
    logic           valid;
    mix_pkg::word_t data;
    logic           last;

    // driven by the sink
    logic           ready;

    // producer side
    modport source (
        output valid,
        output data,
        output last,
        input  ready
    );

    // consumer side
    modport sink (
        input  valid,
        input  data,
        input  last,
        output ready
    );

endinterface

// ==== sim.f ====
design/mix_pkg.sv
design/stream_if.sv
design/pipe_regs.sv
design/mix_lane.sv
design/lane_dispatch.sv
design/lane_collect.sv
design/mix_top.sv
verif/mix_props.sv
verif/tb_mix_top.sv

// ==== verif/mix_props.sv ====
`timescale 1ns/100ps

module mix_props (
    input logic           clk,
    input logic           rst_n,
    input logic           o_valid,
    input logic           i_ready,
    input mix_pkg::word_t o_data,
    input logic           o_last
);

    // failures seen so far, read by the testbench
    int fail_count = 0;

    // a clock edge in reset leaves the output idle
    a_reset_idle: assert property (@(posedge clk) !rst_n |=> !o_valid)
        else begin
            $error("o_valid high after a reset cycle");
            fail_count++;
        end

    // stalled beat holds valid, data and flag
    a_stall_hold: assert property (@(posedge clk) disable iff (!rst_n)
        (o_valid && !i_ready) |=> (o_valid && $stable(o_data) && $stable(o_last)))
        else begin
            $error("output beat changed while stalled");
            fail_count++;
        end

endmodule

bind mix_top mix_props i_props (
    .clk     (clk),
    .rst_n   (rst_n),
    .o_valid (o_valid),
    .i_ready (i_ready),
    .o_data  (o_data),
    .o_last  (o_last)
);

// ==== verif/tb_mix_top.sv ====
`timescale 1ns/100ps

module tb_mix_top;

    localparam int CLK_PERIOD   = 10;
    localparam int RESET_CYCLES = 8;
    localparam int NUM_BEATS    = 2000;
    localparam int WATCHDOG_NS  = NUM_BEATS * 20 * CLK_PERIOD;
    localparam logic [31:0] LFSR_SEED = 32'h086a_fe07;
    // x^32 + x^22 + x^2 + x + 1, right shifting form
    localparam logic [31:0] LFSR_TAPS = 32'h8020_0003;

    logic           clk;
    logic           rst_n;
    logic           i_valid;
    logic           o_ready;
    mix_pkg::word_t i_data;
    logic           i_last;
    logic           o_valid;
    logic           i_ready;
    mix_pkg::word_t o_data;
    logic           o_last;

    logic [31:0]    lfsr_state = LFSR_SEED;
    mix_pkg::beat_t exp_q [$];
    mix_pkg::beat_t exp_beat;
    int             issued     = 0;
    int             out_count  = 0;
    int             stall_left = 0;
    logic           in_fire    = 1'b0;
    logic           held_stall = 1'b0;
    mix_pkg::word_t held_data;
    logic           held_last;

    mix_top i_dut (
        .clk     (clk),
        .rst_n   (rst_n),
        .i_valid (i_valid),
        .o_ready (o_ready),
        .i_data  (i_data),
        .i_last  (i_last),
        .o_valid (o_valid),
        .i_ready (i_ready),
        .o_data  (o_data),
        .o_last  (o_last)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // one galois step, one new bit at the lsb
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        if (s[0]) begin
            return (s >> 1) ^ LFSR_TAPS;
        end else begin
            return s >> 1;
        end
    endfunction

    // collect n bits, the lfsr steps once per bit
    task automatic take_bits(input int n, output logic [31:0] val);
        val = '0;
        for (int i = 0; i < n; i++) begin
            val        = {val[30:0], lfsr_state[0]};
            lfsr_state = lfsr_next(lfsr_state);
        end
    endtask

    // reference: t = x xor rotl(x, MIX_ROT), result t + MIX_KEY, flag on top
    function automatic mix_pkg::beat_t mix_ref(input mix_pkg::word_t x, input logic last);
        mix_pkg::word_t rot;
        for (int i = 0; i < mix_pkg::WORD_W; i++) begin
            rot[(i + mix_pkg::MIX_ROT) % mix_pkg::WORD_W] = x[i];
        end
        return {last, (x ^ rot) + mix_pkg::MIX_KEY};
    endfunction

    task automatic check_word(input string test, input mix_pkg::word_t exp,
                              input mix_pkg::word_t act);
        if (exp !== act) begin
            $display("mismatch %s expected %08h actual %08h", test, exp, act);
            $display("Verification failed");
            $fatal(1, "word compare failed");
        end
    endtask

    task automatic check_last(input string test, input logic exp, input logic act);
        if (exp !== act) begin
            $display("mismatch %s expected %b actual %b", test, exp, act);
            $display("Verification failed");
            $fatal(1, "flag compare failed");
        end
    endtask

    // stop at the first failure of a bound handshake assertion
    task automatic check_assertions;
        if (i_dut.i_props.fail_count != 0) begin
            $display("a handshake assertion on the DUT output failed");
            $display("Verification failed");
            $fatal(1, "assertion failure seen");
        end
    endtask

    // output ready, short random gaps plus occasional long stalls
    task automatic drive_sink;
        logic [31:0] bits;
        if (stall_left > 0) begin
            i_ready    = 1'b0;
            stall_left = stall_left - 1;
        end else begin
            take_bits(4, bits);
            if (bits[3:0] == 4'd0) begin
                take_bits(5, bits);
                stall_left = int'(bits[4:0]) + 8;
                i_ready    = 1'b0;
            end else begin
                take_bits(2, bits);
                i_ready = (bits[1:0] != 2'd0);
            end
        end
    endtask

    // new beat only once the previous one was taken
    task automatic drive_source;
        logic [31:0] bits;
        if (!i_valid || in_fire) begin
            if (issued == NUM_BEATS) begin
                i_valid = 1'b0;
            end else begin
                take_bits(2, bits);
                if (bits[1:0] != 2'd0) begin
                    take_bits(32, bits);
                    i_data = bits;
                    // about one beat in eight ends a packet
                    take_bits(3, bits);
                    i_last  = (bits[2:0] == 3'd0);
                    i_valid = 1'b1;
                    issued  = issued + 1;
                end else begin
                    i_valid = 1'b0;
                end
            end
        end
    endtask

    // transfers are sampled at the rising edge, before the DUT registers move
    always @(posedge clk) begin
        in_fire = rst_n && i_valid && o_ready;
        if (in_fire) begin
            exp_q.push_back(mix_ref(i_data, i_last));
        end
        // a stalled beat must still be there, unchanged
        if (rst_n && held_stall) begin
            check_last("stall_valid", 1'b1, o_valid);
            check_word("stall_data", held_data, o_data);
            check_last("stall_last", held_last, o_last);
        end
        if (rst_n && o_valid && i_ready) begin
            if (exp_q.size() == 0) begin
                $display("output beat appeared with no matching input beat");
                $display("Verification failed");
                $fatal(1, "unexpected output beat");
            end else begin
                exp_beat = exp_q.pop_front();
                check_word("mix_result", exp_beat[mix_pkg::WORD_W-1:0], o_data);
                check_last("last_flag", exp_beat[mix_pkg::WORD_W], o_last);
                out_count = out_count + 1;
            end
        end
        held_stall = rst_n && o_valid && !i_ready;
        held_data  = o_data;
        held_last  = o_last;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("timeout after %0d ns, output stream never drained", WATCHDOG_NS);
        $display("Verification failed");
        $fatal(1, "watchdog expired");
    end

    initial begin
        rst_n   = 1'b0;
        i_valid = 1'b0;
        i_data  = '0;
        i_last  = 1'b0;
        i_ready = 1'b0;

        // output must stay idle through reset
        repeat (RESET_CYCLES) begin
            @(negedge clk);
            check_last("reset_valid", 1'b0, o_valid);
        end
        rst_n = 1'b1;
        @(negedge clk);
        check_last("ready_after_reset", 1'b1, o_ready);

        while (out_count < NUM_BEATS) begin
            drive_sink;
            drive_source;
            check_assertions;
            @(negedge clk);
        end

        // idle tail, any stray output beat trips the monitor
        i_valid = 1'b0;
        i_ready = 1'b1;
        repeat (16) begin
            @(negedge clk);
            check_assertions;
        end

        if (i_dut.i_props.fail_count == 0) begin
            $display("Verification passed");
            $finish;
        end else begin
            $display("Verification failed");
            $fatal(1, "assertion failure seen at end of run");
        end
    end

endmodule
